// ==== fpn_consts.svh ====
/*
 * widths of the normalizer datapath
 * rounding-mode codes
 * canonical binary32 result words
 */
`ifndef FPN_CONSTS_SVH
`define FPN_CONSTS_SVH

// ----------------------------------------------------------------------
// widths
`define FPN_EXP_W     9   // extended exponent incl. wrap bit
`define FPN_MAN_W     23  // stored fraction
`define FPN_EXT_MAN_W 48  // product-wide mantissa from arithmetic stage
`define FPN_INT_W     32  // integer input and upper shift register

// ----------------------------------------------------------------------
// rounding modes, riscv frm encoding
`define FPN_RM_RNE 3'd0  // nearest, ties to even
`define FPN_RM_RTZ 3'd1  // toward zero
`define FPN_RM_RDN 3'd2  // toward -inf
`define FPN_RM_RUP 3'd3  // toward +inf
`define FPN_RM_RMM 3'd4  // nearest, ties to max magnitude

// canonical results
`define FPN_QNAN     32'h7fc0_0000
`define FPN_POS_INF  32'h7f80_0000
`define FPN_POS_ZERO 32'h0000_0000

`endif

// ==== fpn_pkg.sv ====
/*
 * control engine state encoding
 * class and exception flag bit positions
 * vector types shared by the normalizer blocks
 */
`include "fpn_consts.svh"

package fpn_pkg;

    typedef enum logic [3:0] {
        st_idle,
        st_prep_i2f,    // load integer
        st_check_i2f,   // zero integer test
        st_prep_norm,   // load aligned mantissa
        st_prep_shift,  // pick shift direction
        st_norm_busy,   // shifting
        st_round,
        st_check,       // range check
        st_finalize
    } fpn_state_e;

    typedef enum logic [3:0] {
        cls_neg_inf, cls_neg_normal, cls_neg_denorm, cls_neg_zero,
        cls_pos_zero, cls_pos_denorm, cls_pos_normal, cls_pos_inf,
        cls_snan, cls_qnan
    } fpn_class_idx_e;

    typedef enum logic [2:0] {
        flg_nx,  // inexact
        flg_uf,  // underflow
        flg_of,  // overflow
        flg_dz,  // divide by zero passed through
        flg_nv   // invalid
    } fpn_flag_idx_e;

    typedef logic [9:0]                fpn_class_t;  // one-hot
    typedef logic [4:0]                fpn_flags_t;
    typedef logic [2:0]                fpn_rmode_t;
    typedef logic [`FPN_EXP_W-1:0]     fpn_exp_t;
    typedef logic [`FPN_INT_W-1:0]     fpn_word_t;

endpackage

// ==== fpn_if.sv ====
/*
 * fpn_shift_if  commands to and status from the mantissa shifter
 * fpn_exp_if    exponent counter load, step and wrap status
 */
`timescale 1ns/10ps
`include "fpn_consts.svh"

// ----------------------------------------------------------------------
interface fpn_shift_if;
    logic                  load_i2f;    // integer into upper register
    logic                  load_norm;   // aligned mantissa into registers
    logic                  set_dir;     // latch zero status as direction
    logic                  shift_en;    // one shift step
    logic                  round_load;  // write back rounded mantissa
    logic                  res_sgn;     // sign for directed rounding
    logic                  norm_done;   // upper == 1
    logic                  zero;        // upper == 0
    logic                  dir;         // 1 = shift left
    logic [`FPN_MAN_W-1:0] frac;        // lower register
    logic                  round_en;    // increment taken on round_load

    modport ctrl (
        output load_i2f, load_norm, set_dir, shift_en, round_load, res_sgn,
        input  norm_done, zero, dir, frac, round_en
    );
    modport dp (
        input  load_i2f, load_norm, set_dir, shift_en, round_load, res_sgn,
        output norm_done, zero, dir, frac, round_en
    );
endinterface

// ----------------------------------------------------------------------
interface fpn_exp_if;
    import fpn_pkg::*;

    logic     load;      // start of operation
    fpn_exp_t load_val;
    logic     step_en;   // follows shifter shift_en
    logic     step_dn;   // follows shifter dir, left shift counts down
    fpn_exp_t cnt;
    logic     ovf;       // sticky until next load
    logic     unf;

    modport ctrl (output load, load_val, input cnt, ovf, unf);
    modport trk  (input load, load_val, step_en, step_dn, output cnt, ovf, unf);
endinterface

// ==== fpn_shifter.sv ====
/*
 * mantissa shift register with guard, round and sticky bits
 * rounding decision per mode and 25-bit incrementer
 */
`timescale 1ns/10ps
`include "fpn_consts.svh"

module fpn_shifter (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      fused_i,     // fused op, one more integer bit
    input  logic [`FPN_EXT_MAN_W-1:0] mantissa_i,
    input  fpn_pkg::fpn_word_t        integer_i,
    input  fpn_pkg::fpn_rmode_t       rmode_i,
    fpn_shift_if.dp                   sh
);
    logic [`FPN_INT_W-1:0]     upper_q;  // integer part, hidden one at bit 0
    logic [`FPN_MAN_W-1:0]     lower_q;  // fraction
    logic                      g_q;
    logic                      r_q;
    logic                      s_q;
    logic                      dir_q;
    logic [`FPN_EXT_MAN_W:0]   aligned;  // mantissa with binary point fixed
    logic                      rnd_en;
    logic                      lost;     // any bit below the fraction
    logic [`FPN_MAN_W+1:0]     rnd_sum;  // carry, hidden one, fraction

    // fused products carry one extra integer bit
    assign aligned = fused_i ? {mantissa_i, 1'b0} : {1'b0, mantissa_i};

    // ------------------------------------------------------------------
    // datapath registers
    always_ff @(posedge clk_i) begin
        if (sh.load_i2f) begin
            upper_q <= integer_i;
            lower_q <= '0;
            g_q     <= 1'b0;
            r_q     <= 1'b0;
            s_q     <= 1'b0;
        end else if (sh.load_norm) begin
            upper_q <= {29'd0, aligned[48:46]};
            lower_q <= aligned[45:23];
            g_q     <= aligned[22];
            r_q     <= aligned[21];
            s_q     <= |aligned[20:0];         // fold the rest into sticky
        end else if (sh.round_load) begin
            upper_q <= {30'd0, rnd_sum[24:23]}; // carry may need one more shift
            lower_q <= rnd_sum[22:0];
            g_q     <= 1'b0;
            r_q     <= 1'b0;
            s_q     <= 1'b0;
        end else if (sh.shift_en) begin
            if (dir_q) begin                   // left
                upper_q <= {upper_q[30:0], lower_q[22]};
                lower_q <= {lower_q[21:0], g_q};
                g_q     <= r_q;
                r_q     <= s_q;                // sticky replicated
            end else begin                     // right
                upper_q <= {1'b0, upper_q[31:1]};
                lower_q <= {upper_q[0], lower_q[22:1]};
                g_q     <= lower_q[0];
                r_q     <= g_q;
                s_q     <= r_q | s_q;          // sticky accumulates
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            dir_q <= 1'b0;
        end else if (sh.load_i2f) begin
            dir_q <= 1'b0;                     // integers only go right
        end else if (sh.set_dir) begin
            dir_q <= sh.zero;                  // below 1.0 means left
        end
    end

    // ------------------------------------------------------------------
    // rounding decision
    assign lost = g_q | r_q | s_q;

    always_comb begin
        case (rmode_i)
            `FPN_RM_RNE: rnd_en = g_q & (r_q | s_q | lower_q[0]); // tie goes to even lsb
            `FPN_RM_RTZ: rnd_en = 1'b0;                           // truncate
            `FPN_RM_RDN: rnd_en = sh.res_sgn & lost;
            `FPN_RM_RUP: rnd_en = ~sh.res_sgn & lost;
            `FPN_RM_RMM: rnd_en = g_q;
            default:     rnd_en = 1'b0;
        endcase
    end

    assign rnd_sum = {1'b0, upper_q[0], lower_q} + {24'd0, rnd_en};

    assign sh.norm_done = (upper_q == 32'd1);
    assign sh.zero      = (upper_q == '0);
    assign sh.dir       = dir_q;
    assign sh.frac      = lower_q;
    assign sh.round_en  = sh.round_load & rnd_en;

endmodule

// ==== fpn_exp_tracker.sv ====
/*
 * 9-bit exponent counter following the mantissa shifts
 * sticky overflow and underflow from counter wrap-around
 */
`timescale 1ns/10ps

module fpn_exp_tracker (
    input  logic    clk_i,
    input  logic    rstn_i,
    fpn_exp_if.trk  ex
);
    import fpn_pkg::*;

    fpn_exp_t prev_q;  // count one cycle back

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ex.cnt <= '0;
            prev_q <= '0;
            ex.ovf <= 1'b0;
            ex.unf <= 1'b0;
        end else if (ex.load) begin
            ex.cnt <= ex.load_val;
            prev_q <= ex.load_val;           // no false wrap on reload
            ex.ovf <= 1'b0;
            ex.unf <= 1'b0;
        end else begin
            prev_q <= ex.cnt;
            if (ex.step_en) begin
                if (ex.step_dn) begin
                    ex.cnt <= ex.cnt - 1'b1; // left shift
                end else begin
                    ex.cnt <= ex.cnt + 1'b1; // right shift
                end
            end
            // 0x0ff -> 0x100 going up
            if ((prev_q[8:7] == 2'b01) && (ex.cnt[8:7] == 2'b10)) begin
                ex.ovf <= 1'b1;
            end
            // 0x000 -> 0x1ff going down
            if ((prev_q[8:7] == 2'b00) && (ex.cnt[8:7] == 2'b11)) begin
                ex.unf <= 1'b1;
            end
        end
    end

endmodule

// ==== fpn_ctrl.sv ====
/*
 * control engine FSM of the normalizer
 * special-case bypass, range check, result packing, flags
 */
`timescale 1ns/10ps
`include "fpn_consts.svh"

module fpn_ctrl (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                start_i,
    input  logic                funct_i,     // 1 = int-to-float
    input  logic                sign_i,
    input  fpn_pkg::fpn_exp_t   exponent_i,
    input  fpn_pkg::fpn_class_t class_i,
    input  fpn_pkg::fpn_flags_t flags_i,
    fpn_shift_if.ctrl           sh,
    fpn_exp_if.ctrl             ex,
    output fpn_pkg::fpn_word_t  result_o,
    output fpn_pkg::fpn_flags_t flags_o,
    output logic                done_o
);
    import fpn_pkg::*;

    fpn_state_e state_q;
    logic       norm_r_q;   // second normalization pass
    logic       rounded_q;  // increment happened
    logic       sgn_q;
    fpn_class_t class_q;
    fpn_flags_t flags_q;    // working flags
    logic       bypass;     // skip normalization
    logic       shift_stop;
    fpn_word_t  res_word;
    fpn_flags_t fin_flags;

    assign bypass = class_q[cls_snan]       | class_q[cls_qnan]
                  | class_q[cls_neg_zero]   | class_q[cls_pos_zero]
                  | class_q[cls_neg_denorm] | class_q[cls_pos_denorm]
                  | class_q[cls_neg_inf]    | class_q[cls_pos_inf]
                  | flags_q[flg_uf] | flags_q[flg_of] | flags_q[flg_nv];

    assign shift_stop = sh.norm_done | ex.ovf | ex.unf;

    // ------------------------------------------------------------------
    // commands at most one per cycle
    assign sh.load_i2f   = (state_q == st_prep_i2f);
    assign sh.load_norm  = (state_q == st_prep_norm);
    assign sh.set_dir    = (state_q == st_prep_shift);
    assign sh.shift_en   = (state_q == st_norm_busy) && !shift_stop;
    assign sh.round_load = (state_q == st_round);
    assign sh.res_sgn    = sgn_q;
    assign ex.load       = (state_q == st_idle) && start_i;
    // integer operands carry their binary point after bit 31
    assign ex.load_val   = funct_i ? exponent_i - fpn_exp_t'(`FPN_INT_W - 1) : exponent_i;

    // result priority in falling order
    always_comb begin
        if (class_q[cls_snan] || class_q[cls_qnan]) begin
            res_word = `FPN_QNAN;
        end else if (class_q[cls_neg_inf] || class_q[cls_pos_inf] || flags_q[flg_of]) begin
            res_word = `FPN_POS_INF | {sgn_q, 31'd0};
        end else if (class_q[cls_neg_zero] || class_q[cls_pos_zero]) begin
            res_word = `FPN_POS_ZERO | {class_q[cls_neg_zero], 31'd0};
        end else if (flags_q[flg_uf] || sh.zero ||
                     class_q[cls_neg_denorm] || class_q[cls_pos_denorm]) begin
            res_word = `FPN_POS_ZERO | {sgn_q, 31'd0};  // flush to zero
        end else begin
            res_word = {sgn_q, ex.cnt[7:0], sh.frac};
        end
        fin_flags         = flags_q;
        fin_flags[flg_nv] = flags_q[flg_nv] | class_q[cls_snan];
        fin_flags[flg_nx] = flags_q[flg_nx] | rounded_q;
    end

    // ------------------------------------------------------------------
    // state machine
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= st_idle;
            norm_r_q  <= 1'b0;
            rounded_q <= 1'b0;
            sgn_q     <= 1'b0;
            class_q   <= '0;
            flags_q   <= '0;
            result_o  <= '0;
            flags_o   <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (start_i) begin
                        norm_r_q  <= 1'b0;
                        rounded_q <= 1'b0;
                        sgn_q     <= sign_i;
                        class_q   <= class_i;
                        flags_q   <= flags_i;
                        state_q   <= funct_i ? st_prep_i2f : st_prep_norm;
                    end
                end
                st_prep_i2f: state_q <= st_check_i2f;
                st_check_i2f: begin
                    if (sh.zero) begin
                        class_q[cls_pos_zero] <= 1'b1;  // integer 0 gives +0
                        state_q               <= st_finalize;
                    end else begin
                        state_q <= st_norm_busy;
                    end
                end
                st_prep_norm: state_q <= bypass ? st_finalize : st_prep_shift;
                st_prep_shift: state_q <= st_norm_busy;
                st_norm_busy: begin
                    if (shift_stop) begin
                        norm_r_q <= 1'b1;
                        state_q  <= norm_r_q ? st_check : st_round;
                    end
                end
                st_round: begin
                    rounded_q <= rounded_q | sh.round_en;
                    state_q   <= st_prep_shift;          // renormalize once
                end
                st_check: begin
                    if (ex.unf) begin
                        flags_q[flg_uf] <= 1'b1;
                    end else if (ex.ovf) begin
                        flags_q[flg_of] <= 1'b1;
                    end else if (ex.cnt[7:0] == 8'h00) begin
                        flags_q[flg_uf] <= 1'b1;           // subnormal range
                    end else if (ex.cnt[7:0] == 8'hff) begin
                        flags_q[flg_of] <= 1'b1;
                    end
                    state_q <= st_finalize;
                end
                st_finalize: begin
                    result_o <= res_word;
                    flags_o  <= fin_flags;
                    done_o   <= 1'b1;
                    state_q  <= st_idle;
                end
                default: state_q <= st_idle;
            endcase
        end
    end

endmodule

// ==== fpn_normalizer.sv ====
/*
 * normalizer and rounding stage top level
 * control engine, mantissa shifter and exponent tracker
 */
`timescale 1ns/10ps
`include "fpn_consts.svh"

module fpn_normalizer (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      start_i,
    input  fpn_pkg::fpn_rmode_t       rmode_i,
    input  logic                      funct_i,     // 0 norm and round, 1 int-to-float
    input  logic                      fused_i,
    input  logic                      sign_i,
    input  fpn_pkg::fpn_exp_t         exponent_i,
    input  logic [`FPN_EXT_MAN_W-1:0] mantissa_i,
    input  fpn_pkg::fpn_word_t        integer_i,
    input  fpn_pkg::fpn_class_t       class_i,
    input  fpn_pkg::fpn_flags_t       flags_i,
    output fpn_pkg::fpn_word_t        result_o,
    output fpn_pkg::fpn_flags_t       flags_o,
    output logic                      done_o
);
    fpn_shift_if u_sh_if ();
    fpn_exp_if   u_ex_if ();

    // exponent steps track the mantissa shifts
    assign u_ex_if.step_en = u_sh_if.shift_en;
    assign u_ex_if.step_dn = u_sh_if.dir;

    fpn_ctrl u_ctrl (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .start_i    (start_i),
        .funct_i    (funct_i),
        .sign_i     (sign_i),
        .exponent_i (exponent_i),
        .class_i    (class_i),
        .flags_i    (flags_i),
        .sh         (u_sh_if),
        .ex         (u_ex_if),
        .result_o   (result_o),
        .flags_o    (flags_o),
        .done_o     (done_o)
    );

    fpn_shifter u_shifter (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .fused_i    (fused_i),
        .mantissa_i (mantissa_i),
        .integer_i  (integer_i),
        .rmode_i    (rmode_i),
        .sh         (u_sh_if)
    );

    fpn_exp_tracker u_exp_tracker (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .ex     (u_ex_if)
    );

endmodule

// ==== fpn_normalizer_sva.sv ====
/*
 * concurrent assertions on the normalizer top level
 * done pulse shape, done after start, dz pass-through
 */
`timescale 1ns/10ps

module fpn_normalizer_sva (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                start_i,
    input  logic                done_o,
    input  fpn_pkg::fpn_flags_t flags_i,
    input  fpn_pkg::fpn_flags_t flags_o
);
    import fpn_pkg::*;

    logic busy_q;  // operation in flight
    logic dz_q;    // dz captured with start

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
            dz_q   <= 1'b0;
        end else if (start_i && (!busy_q || done_o)) begin
            busy_q <= 1'b1;
            dz_q   <= flags_i[flg_dz];
        end else if (done_o) begin
            busy_q <= 1'b0;
        end
    end

    a_done_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        done_o |=> !done_o) else $error("done_o high for two cycles");
    a_done_after_start: assert property (@(posedge clk_i) disable iff (!rstn_i)
        done_o |-> busy_q) else $error("done_o without a preceding start");
    a_dz_pass: assert property (@(posedge clk_i) disable iff (!rstn_i)
        done_o |-> (flags_o[flg_dz] == dz_q)) else $error("dz flag not passed through");

endmodule

bind fpn_normalizer fpn_normalizer_sva u_sva (.*);

// ==== tb_fpn_normalizer.sv ====
/*
 * testbench of the normalizer and rounding stage
 * reference model, compare process, watchdog and verdict
 */
`timescale 1ns/10ps
`include "fpn_consts.svh"

module tb_fpn_normalizer;
    import fpn_pkg::*;

    localparam int N_SPECIAL = 10;
    localparam int N_I2F     = 41;
    localparam int N_NORM    = 120;
    localparam int N_TIES    = 4;
    localparam int N_RANGE   = 8;
    localparam int N_FLAGS   = 4;
    localparam int N_OPS     = N_SPECIAL + N_I2F + N_NORM + N_TIES + N_RANGE + N_FLAGS;

    logic clk_i, rstn_i, start_i, funct_i, fused_i, sign_i, done_o;
    fpn_rmode_t  rmode_i;
    fpn_exp_t    exponent_i;
    logic [47:0] mantissa_i;
    fpn_word_t   integer_i, result_o;
    fpn_class_t  class_i;
    fpn_flags_t  flags_i, flags_o;

    fpn_word_t   exp_word_q[$];   // expected results in issue order
    fpn_flags_t  exp_flags_q[$];
    logic [31:0] rng = 32'h30df_d677;
    int          n_mismatch = 0;
    int          n_timeout  = 0;
    int          n_other    = 0;

    fpn_normalizer u_fpn_normalizer (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;  // 20 ns
    end

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // ----------------------------------------------------------------------
    // reference model of value src * 2^(exp - 127 - point)
    function automatic logic [36:0] ref_normalize(input logic funct, fused, sign,
            input fpn_exp_t ex, input logic [47:0] m, input fpn_word_t iv,
            input fpn_rmode_t rm, input fpn_class_t cl, input fpn_flags_t fl);
        logic [47:0] src;
        logic [71:0] sh;
        logic [24:0] sum;
        logic [22:0] frac;
        logic        g, r, s, inc, nan, inf, zc, dn, of_r, uf_r;
        int          k, e, p;
        fpn_flags_t  f;
        fpn_word_t   w;
        nan  = cl[cls_snan] | cl[cls_qnan];
        inf  = cl[cls_neg_inf] | cl[cls_pos_inf];
        zc   = cl[cls_neg_zero] | cl[cls_pos_zero];
        dn   = cl[cls_neg_denorm] | cl[cls_pos_denorm];
        f    = fl;
        of_r = fl[flg_of];
        uf_r = fl[flg_uf];
        inc  = 1'b0;
        frac = '0;
        e    = 0;
        if (funct && iv == '0) begin
            zc = 1'b1;                              // integer zero is +0
        end else if (funct || !(nan | inf | zc | dn | of_r | uf_r | fl[flg_nv])) begin
            src = funct ? {16'd0, iv} : m;
            p   = funct ? 31 : (fused ? 45 : 46);  // weight 2^0 bit
            k   = 47;
            while (k > 0 && !src[k]) k--;           // leading one
            sh  = {src, 24'd0} << (47 - k);
            g   = sh[47];
            r   = sh[46];
            s   = |sh[45:0];
            case (rm)
                `FPN_RM_RNE: inc = g & (r | s | sh[48]);
                `FPN_RM_RDN: inc = sign & (g | r | s);
                `FPN_RM_RUP: inc = ~sign & (g | r | s);
                `FPN_RM_RMM: inc = g;
                default:     inc = 1'b0;
            endcase
            sum  = {1'b0, sh[71:48]} + inc;
            e    = int'(ex) + k - p + int'(sum[24]);   // carry renormalizes
            frac = sum[24] ? sum[23:1] : sum[22:0];
            if (e >= 255) of_r = 1'b1;
            else if (e <= 0) uf_r = 1'b1;
            f[flg_of] = f[flg_of] | of_r;
            f[flg_uf] = f[flg_uf] | uf_r;
        end
        if (nan) w = `FPN_QNAN;
        else if (inf || of_r) w = `FPN_POS_INF | {sign, 31'd0};
        else if (zc) w = {cl[cls_neg_zero], 31'd0};
        else if (uf_r || dn) w = {sign, 31'd0};    // flush to zero
        else w = {sign, e[7:0], frac};
        f[flg_nv] = f[flg_nv] | cl[cls_snan];
        f[flg_nx] = f[flg_nx] | inc;
        return {w, f};
    endfunction

    // ----------------------------------------------------------------------
    task automatic check_word(input string name, input fpn_word_t got, input fpn_word_t exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flags(input string name, input fpn_flags_t got,
                               input fpn_flags_t exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // compare process samples at the falling edge
    always @(negedge clk_i) begin
        if (rstn_i && done_o) begin
            if (exp_word_q.size() == 0) begin
                n_other++;
                $display("done_o came with no operation outstanding");
            end else begin
                check_word("result_o", result_o, exp_word_q.pop_front());
                check_flags("flags_o", flags_o, exp_flags_q.pop_front());
            end
        end
    end

    task automatic run_op(input logic funct, fused, sign, input fpn_exp_t ex,
            input logic [47:0] m, input fpn_word_t iv, input fpn_rmode_t rm,
            input fpn_class_t cl, input fpn_flags_t fl);
        logic [36:0] exp_v;
        bit          seen;
        exp_v = ref_normalize(funct, fused, sign, ex, m, iv, rm, cl, fl);
        exp_word_q.push_back(exp_v[36:5]);
        exp_flags_q.push_back(exp_v[4:0]);
        @(posedge clk_i);
        #1;
        {funct_i, fused_i, sign_i, exponent_i, mantissa_i} = {funct, fused, sign, ex, m};
        {integer_i, rmode_i, class_i, flags_i} = {iv, rm, cl, fl};
        start_i = 1'b1;
        @(posedge clk_i);
        #1;
        start_i = 1'b0;
        seen = 1'b0;
        for (int c = 0; c < 200 && !seen; c++) begin
            @(negedge clk_i);
            seen = done_o;
        end
        if (!seen) begin
            n_timeout++;
            $display("timeout: done_o never came for the current operation");
            $display("errors: %0d mismatches, %0d timeouts, %0d other", n_mismatch,
                     n_timeout, n_other);
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    // mantissa with one right shift at most or exactly one left shift
    function automatic logic [47:0] make_mant(input logic fused, input int pick);
        logic [47:0] m;
        m = 48'({xorshift(), xorshift()});
        if (pick == 3) begin
            if (fused) m[47:44] = 4'b0001;
            else m[47:45] = 3'b001;
        end else if (fused && m[47:45] == 3'b000) begin
            m[45] = 1'b1;
        end else if (!fused && m[47:46] == 2'b00) begin
            m[46] = 1'b1;
        end
        return m;
    endfunction

    function automatic fpn_class_t normal_cls(input logic sign);
        return fpn_class_t'(1) << (sign ? cls_neg_normal : cls_pos_normal);
    endfunction

    // ----------------------------------------------------------------------
    initial begin
        logic [47:0] m;
        fpn_word_t   iv;
        logic        sg;
        {rstn_i, start_i, funct_i, fused_i, sign_i, rmode_i} = '0;
        {exponent_i, mantissa_i, integer_i, class_i, flags_i} = '0;
        repeat (2) @(posedge clk_i);
        #1 rstn_i = 1'b1;

        // special classes with sign following class
        for (int i = 0; i < N_SPECIAL; i++) begin
            sg = (i < 4);
            run_op(0, 0, sg, 9'd100, make_mant(0, 0), 0, `FPN_RM_RNE,
                   fpn_class_t'(1) << i, 0);
        end
        // int-to-float with the point after bit 31
        for (int md = 0; md < 5; md++) begin
            for (int i = 0; i < 8; i++) begin
                iv = xorshift() >> (xorshift() % 32);
                if (iv == 0) iv = 32'd1;
                run_op(1, 0, 0, 9'd158, 0, iv, fpn_rmode_t'(md), normal_cls(0), 0);
            end
        end
        run_op(1, 0, 0, 9'd158, 0, 0, `FPN_RM_RNE, normal_cls(0), 0);
        // normalize and round in both alignments
        for (int fu = 0; fu < 2; fu++) begin
            for (int md = 0; md < 5; md++) begin
                for (int i = 0; i < 12; i++) begin
                    sg = 1'(xorshift());
                    run_op(0, fu[0], sg, fpn_exp_t'(20 + xorshift() % 210),
                           make_mant(fu[0], i % 4), 0, fpn_rmode_t'(md), normal_cls(sg),
                           {1'b0, i[0], 3'b0});
                end
            end
        end
        // exact ties with guard set and nothing below
        for (int i = 0; i < N_TIES; i++) begin
            m = (make_mant(0, 1) & 48'h7fff_ff80_0000) | 48'h4000_0040_0000;
            m[23] = i[0];                            // lsb
            run_op(0, 0, 0, 9'd120, m, 0, (i < 2) ? `FPN_RM_RNE : `FPN_RM_RMM,
                   normal_cls(0), 0);
        end
        // range edges
        m = make_mant(0, 0);
        run_op(0, 0, 1, 9'd254, m | 48'h8000_0000_0000, 0, `FPN_RM_RTZ, normal_cls(1), 0);
        run_op(0, 0, 0, 9'd255, (m & 48'h3fff_ffff_ffff) | 48'h4000_0000_0000, 0,
               `FPN_RM_RTZ, normal_cls(0), 0);
        run_op(0, 0, 0, 9'd255, m | 48'h8000_0000_0000, 0, `FPN_RM_RTZ, normal_cls(0), 0);
        run_op(0, 0, 0, 9'd254, 48'h7fff_ffff_ffff, 0, `FPN_RM_RNE, normal_cls(0), 0);
        run_op(0, 0, 1, 9'd0, (m & 48'h3fff_ffff_ffff) | 48'h4000_0000_0000, 0,
               `FPN_RM_RTZ, normal_cls(1), 0);
        run_op(0, 0, 0, 9'd1, make_mant(0, 3), 0, `FPN_RM_RTZ, normal_cls(0), 0);
        run_op(0, 0, 1, 9'd0, make_mant(0, 3), 0, `FPN_RM_RTZ, normal_cls(1), 0);
        run_op(0, 0, 0, 9'd1, (m & 48'h3fff_ffff_ffff) | 48'h4000_0000_0000, 0,
               `FPN_RM_RTZ, normal_cls(0), 0);
        // incoming flags skip normalization
        run_op(0, 0, 1, 9'd90, m, 0, `FPN_RM_RNE, normal_cls(1), 5'b00100);
        run_op(0, 0, 1, 9'd90, m, 0, `FPN_RM_RNE, normal_cls(1), 5'b01010);
        run_op(0, 0, 0, 9'd90, m, 0, `FPN_RM_RNE, normal_cls(0), 5'b10100);
        run_op(0, 0, 0, 9'd90, m, 0, `FPN_RM_RNE, fpn_class_t'(1) << cls_qnan, 5'b10000);

        repeat (3) @(posedge clk_i);
        if (exp_word_q.size() != 0) begin
            n_other++;
            $display("%0d operations never completed", exp_word_q.size());
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d other", n_mismatch, n_timeout,
                 n_other);
        if (n_mismatch + n_timeout + n_other == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog sized from the operation count
    initial begin
        repeat (200 * N_OPS) @(posedge clk_i);
        $display("watchdog expired before all operations finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
fpn_pkg.sv
fpn_if.sv
fpn_shifter.sv
fpn_exp_tracker.sv
fpn_ctrl.sv
fpn_normalizer.sv
fpn_normalizer_sva.sv
tb_fpn_normalizer.sv

// ==== run.sh ====
#!/bin/sh
# build and run the normalizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_fpn_normalizer -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    echo "simulation log holds no verdict"
    exit 1
fi
exit 0
